// ==== tnn_pkg.sv ====
`default_nettype none

package tnn_pkg;

  // Network sizes.
  localparam int feat_cnt    = 8;
  localparam int feat_bits   = 4;
  localparam int half_hidden = 4;
  localparam int hidden_cnt  = 2 * half_hidden;
  localparam int class_cnt   = 4;
  localparam int class_bits  = 2;

  // Datapath widths. Eight features of up to 15 need 8 signed bits,
  // and a class score ranges over plus or minus hidden_cnt.
  localparam int acc_bits   = 8;
  localparam int score_bits = 5;

  // The shared step counter runs from 0 up to feat_cnt inclusive.
  localparam int cnt_bits = $clog2(feat_cnt + 1);
  localparam int sel_bits = $clog2(feat_cnt);

  // First-layer weights, one byte per neuron with neuron 0 in the low byte.
  // A set mask bit marks a nonzero weight, and the sign bit then picks +1 (set) or -1.
  localparam logic [half_hidden*feat_cnt-1:0] mask_a = 32'hC3_3D_A5_29;
  localparam logic [half_hidden*feat_cnt-1:0] sign_a = 32'h81_24_A0_49;
  localparam logic [half_hidden*feat_cnt-1:0] mask_b = 32'hF7_0F_91_66;
  localparam logic [half_hidden*feat_cnt-1:0] sign_b = 32'h50_0A_18_42;

  // Output weights, one byte per class over the eight hidden bits.
  localparam logic [class_cnt*hidden_cnt-1:0] out_mask = 32'hF1_3C_C3_5A;
  localparam logic [class_cnt*hidden_cnt-1:0] out_sign = 32'h91_28_43_1A;

  // Returns the slot of bit pos in the sparse list of a row, which is the
  // number of set bits below it. Gives -1 when no bit up to pos is set.
  function automatic int nth(input logic [feat_cnt-1:0] row, input int pos);
    int idx;
    idx = -1;
    for (int j = 0; j <= pos; j++) begin
      if (row[j]) begin
        idx = idx + 1;
      end
    end
    return idx;
  endfunction

  // Number of nonzero weights of one neuron.
  function automatic int nnz_cnt(input logic [half_hidden*feat_cnt-1:0] mask,
                                 input int row);
    return nth(mask[row*feat_cnt +: feat_cnt], feat_cnt - 1) + 1;
  endfunction

  // Longest sparse list over all neurons of a mask; sets the layer latency.
  function automatic int max_len(input logic [half_hidden*feat_cnt-1:0] mask);
    int longest;
    longest = 0;
    for (int r = 0; r < half_hidden; r++) begin
      if (nnz_cnt(mask, r) > longest) begin
        longest = nnz_cnt(mask, r);
      end
    end
    return longest;
  endfunction

endpackage

`default_nettype wire

// ==== layer_if.sv ====
`default_nettype none

// Link between a sparse layer, the top level that feeds it and the vote
// layer that reads its hidden bits.
interface layer_if;

  logic                                                 start;
  logic [tnn_pkg::feat_cnt-1:0][tnn_pkg::feat_bits-1:0] features;
  logic [tnn_pkg::half_hidden-1:0]                      hidden;
  logic                                                 done;

  modport layer (
    input  start,
    input  features,
    output hidden,
    output done
  );

  // The vote layer only looks at results.
  modport sink (
    input hidden,
    input done
  );

endinterface

`default_nettype wire

// ==== ternary_accumulator.sv ====
`default_nettype none

module ternary_accumulator #(
  parameter int size = 1
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                clear,
  input  logic                                halt,
  input  logic signed [tnn_pkg::acc_bits-1:0] sample,
  output logic                                out
);

  // The sum of size features of at most 15 each needs fewer bits than the
  // shared sample width, so the register is trimmed to what this neuron needs.
  // Partial sums stay inside the same range, so no bits are lost.
  localparam int sum_bits = $clog2((2 ** tnn_pkg::feat_bits - 1) * size + 1) + 1;

  logic signed [sum_bits-1:0] sum;
  logic signed [sum_bits-1:0] addend;

  assign addend = $signed(sample[sum_bits-1:0]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (!halt) begin
      sum <= sum + addend;
    end
  end

  // Binary activation. A zero sum counts as positive.
  assign out = ~sum[sum_bits-1];

endmodule

`default_nettype wire

// ==== sparse_ternary_layer.sv ====
`default_nettype none

module sparse_ternary_layer #(
  parameter logic [tnn_pkg::half_hidden*tnn_pkg::feat_cnt-1:0] mask = '1,
  parameter logic [tnn_pkg::half_hidden*tnn_pkg::feat_cnt-1:0] sign = '1
) (
  input logic    clk,
  input logic    rst,
  layer_if.layer lyr
);

  // Steps needed before every neuron of this half has seen all its features.
  localparam int len = tnn_pkg::max_len(mask);

  logic [tnn_pkg::feat_cnt-1:0][tnn_pkg::feat_bits-1:0] feat_q;
  logic [tnn_pkg::cnt_bits-1:0]                         cnt;
  logic [tnn_pkg::sel_bits-1:0]                         sel;
  logic                                                 active;
  logic                                                 last;
  logic [tnn_pkg::half_hidden-1:0]                      hidden_bits;

  // Features are held for the whole computation.
  always_ff @(posedge clk) begin
    if (lyr.start) begin
      feat_q <= lyr.features;
    end
  end

  assign last = (cnt == tnn_pkg::cnt_bits'(len));

  // One counter walks the sparse lists of all neurons in step. It stops at
  // len, not len - 1, so that the halt of the longest neuron also asserts.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt    <= '0;
      active <= 1'b0;
    end else if (lyr.start) begin
      cnt    <= '0;
      active <= 1'b1;
    end else if (active && !last) begin
      cnt <= cnt + 1'b1;
    end
  end

  // At a count of feat_cnt the low bits wrap to slot 0; every neuron is
  // halted by then, so the value is never added.
  assign sel = cnt[tnn_pkg::sel_bits-1:0];

  for (genvar i = 0; i < tnn_pkg::half_hidden; i++) begin : g_neuron
    localparam logic [tnn_pkg::feat_cnt-1:0] row_mask =
      mask[i*tnn_pkg::feat_cnt +: tnn_pkg::feat_cnt];
    localparam logic [tnn_pkg::feat_cnt-1:0] row_sign =
      sign[i*tnn_pkg::feat_cnt +: tnn_pkg::feat_cnt];
    localparam int row_nnz = tnn_pkg::nnz_cnt(mask, i);

    logic signed [tnn_pkg::acc_bits-1:0] list [tnn_pkg::feat_cnt];
    logic                                halt;

    // Pack the selected features, negated where the weight is -1, into the
    // low slots of the list in order of their mask bits.
    for (genvar j = 0; j < tnn_pkg::feat_cnt; j++) begin : g_feat
      if (row_mask[j]) begin : g_used
        if (row_sign[j]) begin : g_pos
          assign list[tnn_pkg::nth(row_mask, j)] =
            $signed({{(tnn_pkg::acc_bits - tnn_pkg::feat_bits){1'b0}}, feat_q[j]});
        end else begin : g_neg
          assign list[tnn_pkg::nth(row_mask, j)] =
            -$signed({{(tnn_pkg::acc_bits - tnn_pkg::feat_bits){1'b0}}, feat_q[j]});
        end
      end
    end

    // Unused tail slots.
    for (genvar k = row_nnz; k < tnn_pkg::feat_cnt; k++) begin : g_pad
      assign list[k] = '0;
    end

    assign halt = !active || (cnt >= tnn_pkg::cnt_bits'(row_nnz));

    ternary_accumulator #(
      .size (row_nnz)
    ) u_acc (
      .clk    (clk),
      .rst    (rst),
      .clear  (lyr.start),
      .halt   (halt),
      .sample (list[sel]),
      .out    (hidden_bits[i])
    );
  end

  assign lyr.hidden = hidden_bits;
  assign lyr.done   = active && last;

endmodule

`default_nettype wire

// ==== class_vote_layer.sv ====
`default_nettype none

module class_vote_layer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  layer_if.sink                          half_a,
  layer_if.sink                          half_b,
  output logic [tnn_pkg::class_bits-1:0] class_id,
  output logic                           valid
);

  logic [tnn_pkg::hidden_cnt-1:0]        hidden_all;
  logic signed [tnn_pkg::score_bits-1:0] score [tnn_pkg::class_cnt];
  logic signed [tnn_pkg::score_bits-1:0] best_score;
  logic [tnn_pkg::class_bits-1:0]        best_idx;
  logic                                  armed;
  logic                                  fire;

  assign hidden_all = {half_b.hidden, half_a.hidden};

  // A hidden bit of 1 stands for +1 and 0 for -1, so the product with a
  // ternary weight is +1 exactly when the bit equals the weight's sign bit.
  always_comb begin
    for (int c = 0; c < tnn_pkg::class_cnt; c++) begin
      score[c] = '0;
      for (int h = 0; h < tnn_pkg::hidden_cnt; h++) begin
        if (tnn_pkg::out_mask[c*tnn_pkg::hidden_cnt + h]) begin
          if (tnn_pkg::out_sign[c*tnn_pkg::hidden_cnt + h] == hidden_all[h]) begin
            score[c] = score[c] + tnn_pkg::score_bits'(1);
          end else begin
            score[c] = score[c] - tnn_pkg::score_bits'(1);
          end
        end
      end
    end
  end

  // Strict compare keeps the lowest index on a tie.
  always_comb begin
    best_score = score[0];
    best_idx   = '0;
    for (int c = 1; c < tnn_pkg::class_cnt; c++) begin
      if (score[c] > best_score) begin
        best_score = score[c];
        best_idx   = tnn_pkg::class_bits'(c);
      end
    end
  end

  // A start in the same cycle aborts the finished run, so it blocks firing.
  assign fire = armed && half_a.done && half_b.done && !start;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      armed <= 1'b0;
      valid <= 1'b0;
    end else begin
      valid <= fire;
      if (start) begin
        armed <= 1'b1;
      end else if (fire) begin
        armed <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      class_id <= best_idx;
    end
  end

endmodule

`default_nettype wire

// ==== tnn_classifier.sv ====
`default_nettype none

module tnn_classifier (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          start,
  input  logic [tnn_pkg::feat_cnt*tnn_pkg::feat_bits-1:0] features,
  output logic [tnn_pkg::class_bits-1:0]                class_id,
  output logic                                          valid
);

  layer_if if_a ();
  layer_if if_b ();

  // Both halves see the same start and the same features.
  assign if_a.start    = start;
  assign if_a.features = features;
  assign if_b.start    = start;
  assign if_b.features = features;

  sparse_ternary_layer #(
    .mask (tnn_pkg::mask_a),
    .sign (tnn_pkg::sign_a)
  ) u_half_a (
    .clk (clk),
    .rst (rst),
    .lyr (if_a.layer)
  );

  sparse_ternary_layer #(
    .mask (tnn_pkg::mask_b),
    .sign (tnn_pkg::sign_b)
  ) u_half_b (
    .clk (clk),
    .rst (rst),
    .lyr (if_b.layer)
  );

  class_vote_layer u_vote (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .half_a   (if_a.sink),
    .half_b   (if_b.sink),
    .class_id (class_id),
    .valid    (valid)
  );

endmodule

`default_nettype wire

// ==== tnn_classifier_sva.sv ====
`default_nettype none

module tnn_classifier_sva (
  input logic                           clk,
  input logic                           rst,
  input logic                           start,
  input logic [tnn_pkg::class_bits-1:0] class_id,
  input logic                           valid
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of assertion failures so far; the testbench watches it.
  int unsigned fail_cnt = 0;

  logic        started;
  logic        pending;
  logic        seen_valid;
  int unsigned since_start;

  // Tracks whether a start is waiting for its result and how long ago the
  // latest start was seen.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      started     <= 1'b0;
      pending     <= 1'b0;
      seen_valid  <= 1'b0;
      since_start <= 0;
    end else begin
      if (start) begin
        started     <= 1'b1;
        pending     <= 1'b1;
        since_start <= 0;
      end else begin
        if (valid) begin
          pending <= 1'b0;
        end
        if (pending) begin
          since_start <= since_start + 1;
        end
      end
      if (valid) begin
        seen_valid <= 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |-> !valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid is high during reset");
    end

  a_no_early_valid: assert property (@(posedge clk) disable iff (rst) !started |-> !valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid rose before the first start");
    end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid stayed high for more than one cycle");
    end

  a_needs_start: assert property (@(posedge clk) disable iff (rst) valid |-> pending)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid without an outstanding start");
    end

  // Valid may come at the latest on the ninth edge after start.
  a_latency: assert property (@(posedge clk) disable iff (rst)
                              pending && !valid |-> since_start < 9)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("no valid within 9 cycles of start");
    end

  a_class_known: assert property (@(posedge clk) disable iff (rst)
                                  valid |-> !$isunknown(class_id))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("class_id has unknown bits while valid is high");
    end

  a_class_held: assert property (@(posedge clk) disable iff (rst)
                                 seen_valid && !valid |-> $stable(class_id))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("class_id changed between two valid pulses");
    end

endmodule

bind tnn_classifier tnn_classifier_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .start    (start),
  .class_id (class_id),
  .valid    (valid)
);

`default_nettype wire

// ==== tb_tnn_classifier.sv ====
`default_nettype none

module tb_tnn_classifier;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int random_cnt  = 200;
  localparam int test_cnt    = 2 + tnn_pkg::feat_cnt + random_cnt + 1;
  localparam int cycle_limit = test_cnt * 20 + 200;

  logic                                          clk;
  logic                                          rst;
  logic                                          start;
  logic [tnn_pkg::feat_cnt*tnn_pkg::feat_bits-1:0] features;
  logic [tnn_pkg::class_bits-1:0]                class_id;
  logic                                          valid;
  int                                            cycles;

  tnn_classifier tnn_classifier_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .features (features),
    .class_id (class_id),
    .valid    (valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Weighted sum of one first-layer neuron, straight from the ternary weights.
  function automatic int neuron_sum(input logic [31:0] mask, input logic [31:0] sign,
                                    input int n, input logic [31:0] vec);
    int sum;
    int value;
    sum = 0;
    for (int j = 0; j < tnn_pkg::feat_cnt; j++) begin
      value = int'(vec[j*tnn_pkg::feat_bits +: tnn_pkg::feat_bits]);
      if (mask[n*tnn_pkg::feat_cnt + j]) begin
        if (sign[n*tnn_pkg::feat_cnt + j]) begin
          sum = sum + value;
        end else begin
          sum = sum - value;
        end
      end
    end
    return sum;
  endfunction

  // Expected class: hidden bits, then class scores, then the first largest score.
  function automatic logic [tnn_pkg::class_bits-1:0] model_class(input logic [31:0] vec);
    logic [tnn_pkg::hidden_cnt-1:0] hid;
    int score;
    int weight;
    int act;
    int best_score;
    int best_idx;
    for (int n = 0; n < tnn_pkg::half_hidden; n++) begin
      hid[n] = neuron_sum(tnn_pkg::mask_a, tnn_pkg::sign_a, n, vec) >= 0;
      hid[n + tnn_pkg::half_hidden] = neuron_sum(tnn_pkg::mask_b, tnn_pkg::sign_b, n, vec) >= 0;
    end
    best_score = -1000;
    best_idx   = 0;
    for (int c = 0; c < tnn_pkg::class_cnt; c++) begin
      score = 0;
      for (int h = 0; h < tnn_pkg::hidden_cnt; h++) begin
        if (tnn_pkg::out_mask[c*tnn_pkg::hidden_cnt + h]) begin
          weight = tnn_pkg::out_sign[c*tnn_pkg::hidden_cnt + h] ? 1 : -1;
          act    = hid[h] ? 1 : -1;
          score  = score + weight * act;
        end
      end
      if (score > best_score) begin
        best_score = score;
        best_idx   = c;
      end
    end
    return tnn_pkg::class_bits'(best_idx);
  endfunction

  task automatic check_result(input string name, input logic [tnn_pkg::class_bits-1:0] expected);
    assert (class_id === expected) else begin
      $display("mismatch %s expected %0d actual %0d", name, expected, class_id);
      $display("*** FAILED ***");
      $fatal(1, "class_id differs from the reference model");
    end
  endtask

  // Called on a falling edge; returns on the falling edge after the valid cycle.
  task automatic run_vector(input string name, input logic [31:0] vec);
    logic [tnn_pkg::class_bits-1:0] expected;
    expected = model_class(vec);
    features = vec;
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (valid !== 1'b1) begin
      @(negedge clk);
    end
    check_result(name, expected);
    @(negedge clk);
  endtask

  // A second start three cycles into a run must replace the first one.
  task automatic run_restart(input logic [31:0] first_vec, input logic [31:0] second_vec);
    logic [tnn_pkg::class_bits-1:0] expected;
    int valid_seen;
    expected   = model_class(second_vec);
    valid_seen = 0;
    features   = first_vec;
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (valid === 1'b1) valid_seen++;
    end
    features = second_vec;
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (valid !== 1'b1) begin
      @(negedge clk);
    end
    valid_seen++;
    check_result("restart", expected);
    repeat (12) begin
      @(negedge clk);
      if (valid === 1'b1) valid_seen++;
    end
    assert (valid_seen == 1) else begin
      $display("restart produced %0d valid pulses instead of one", valid_seen);
      $display("*** FAILED ***");
      $fatal(1, "wrong number of results after a restart");
    end
  endtask

  // Ends the run on a timeout or on any concurrent assertion failure.
  initial begin : watchdog
    cycles = 0;
    while (cycles < cycle_limit && tnn_classifier_inst.u_sva.fail_cnt == 0) begin
      @(posedge clk);
      cycles++;
    end
    if (cycles >= cycle_limit) begin
      $display("timeout reached after %0d cycles", cycles);
    end else begin
      $display("a concurrent assertion on the DUT ports failed");
    end
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  end

  initial begin : stimulus
    rst      = 1'b1;
    start    = 1'b0;
    features = '0;
    void'($urandom(32'h87f2_867c));
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);

    run_vector("zeros", 32'h0000_0000);
    run_vector("fifteens", 32'hFFFF_FFFF);
    for (int k = 0; k < tnn_pkg::feat_cnt; k++) begin
      run_vector($sformatf("onehot%0d", k), 32'hF << (k * tnn_pkg::feat_bits));
    end
    for (int i = 0; i < random_cnt; i++) begin
      run_vector($sformatf("random%0d", i), $urandom);
    end
    run_restart($urandom, $urandom);

    repeat (2) @(negedge clk);
    if (tnn_classifier_inst.u_sva.fail_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "concurrent assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== tnn_classifier.f ====
tnn_pkg.sv
layer_if.sv
ternary_accumulator.sv
sparse_ternary_layer.sv
class_vote_layer.sv
tnn_classifier.sv
tnn_classifier_sva.sv
tb_tnn_classifier.sv

// ==== Makefile ====
# Verilator build for the ternary network classifier.
# Any variable below can be overridden on the command line,
# for example: make sim VERILATOR_FLAGS="--binary --timing --assert"

VERILATOR       ?= verilator
TOP             ?= tb_tnn_classifier
FILELIST        ?= tnn_classifier.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only --timing --assert
# Keep the run going after a concurrent assertion error so that the
# testbench can report the failure and end with $fatal.
SIM_ARGS        ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits with a failing status on $fatal, so make fails too.
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
